/* hw/alu_consts.svh */
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// operand and result width
`define ALU_DATA_W      32

// fifo depths, kept to powers of two
`define ALU_CMD_DEPTH   4
`define ALU_RES_DEPTH   4

// bits looked at per cycle by cpop and ctz
`define ALU_CNT_STEP    4

// apb register byte offsets
`define ALU_REG_OP1     8'h00
`define ALU_REG_OP2     8'h04
`define ALU_REG_CMD     8'h08
`define ALU_REG_RESULT  8'h0C
`define ALU_REG_FLAGS   8'h10
`define ALU_REG_STATUS  8'h14

`endif

/* hw/alu_pkg.sv */
`include "alu_consts.svh"

package alu_pkg;

    typedef logic [`ALU_DATA_W-1:0] data_t;

    // {equal, signed less-than, unsigned less-than} of op1 against op2
    typedef logic [2:0] flags_t;

    typedef logic [5:0] step_cnt_t;

    // codes 0 to 20, in this order
    typedef enum logic [4:0] {
        UOP_AND, UOP_OR, UOP_XOR, UOP_SLL, UOP_SRL, UOP_SRA, UOP_SLT,
        UOP_SLTU, UOP_ADD, UOP_SUB, UOP_MUL, UOP_MULH, UOP_DIV, UOP_DIVU,
        UOP_REM, UOP_REMU, UOP_CPOP, UOP_CTZ, UOP_PACK, UOP_REV8, UOP_SH1ADD
    } uop_e;

    typedef struct packed {
        uop_e  uop;
        data_t op1;
        data_t op2;
    } cmd_t;

    typedef struct packed {
        data_t  data;
        flags_t flags;
    } res_t;

    typedef enum logic [1:0] {
        IDLE,
        DIVIDE,
        COUNT,
        EMIT
    } core_state_e;

endpackage

/* hw/alu_if.sv */
`timescale 1ns/1ps

// command stream, source holds valid and payload until ready
interface cmd_if;
    logic          valid;
    logic          ready;
    alu_pkg::cmd_t payload;

    modport src (output valid, output payload, input ready);
    modport snk (input valid, input payload, output ready);
endinterface

// result stream, same handshake
interface res_if;
    logic          valid;
    logic          ready;
    alu_pkg::res_t payload;

    modport src (output valid, output payload, input ready);
    modport snk (input valid, input payload, output ready);
endinterface

/* hw/apb_cmd_port.sv */
`timescale 1ns/1ps
`include "alu_consts.svh"

module apb_cmd_port (
    input  logic           clk_i,
    input  logic           rstn_i,
    input  logic           psel_i,
    input  logic           penable_i,
    input  logic           pwrite_i,
    input  logic [7:0]     paddr_i,
    input  alu_pkg::data_t pwdata_i,
    output alu_pkg::data_t prdata_o,
    output logic           pready_o,
    output logic           pslverr_o,
    cmd_if.src             cmd,
    res_if.snk             res,
    input  logic [2:0]     cmd_count_i,
    input  logic [2:0]     res_count_i
);

    alu_pkg::data_t  op1_q;
    alu_pkg::data_t  op2_q;
    alu_pkg::flags_t flags_q;

    logic access;
    logic mapped;
    logic bad_uop;
    logic err;
    logic cmd_wr;
    logic res_rd;

    assign access  = psel_i && penable_i;
    assign mapped  = paddr_i inside {`ALU_REG_OP1, `ALU_REG_OP2, `ALU_REG_CMD,
                                     `ALU_REG_RESULT, `ALU_REG_FLAGS, `ALU_REG_STATUS};
    assign bad_uop = pwdata_i[4:0] > 5'(alu_pkg::UOP_SH1ADD);
    assign cmd_wr  = pwrite_i && (paddr_i == `ALU_REG_CMD);
    assign res_rd  = !pwrite_i && (paddr_i == `ALU_REG_RESULT);
    assign err     = !mapped || (cmd_wr && bad_uop);

    // a rejected code never reaches the fifo
    assign cmd.valid   = access && cmd_wr && !bad_uop;
    assign cmd.payload = '{uop: alu_pkg::uop_e'(pwdata_i[4:0]), op1: op1_q, op2: op2_q};
    assign res.ready   = access && res_rd;

    // stall on a full command fifo or an empty result fifo
    always_comb begin
        pready_o = access;
        if (access && !err) begin
            if (cmd_wr) begin
                pready_o = cmd.ready;
            end else if (res_rd) begin
                pready_o = res.valid;
            end
        end
    end

    assign pslverr_o = access && err;

    always_comb begin
        prdata_o = '0;
        case (paddr_i)
            `ALU_REG_OP1:    prdata_o = op1_q;
            `ALU_REG_OP2:    prdata_o = op2_q;
            `ALU_REG_RESULT: prdata_o = res.payload.data;
            `ALU_REG_FLAGS:  prdata_o[2:0] = flags_q;
            `ALU_REG_STATUS: begin
                prdata_o[2:0] = cmd_count_i;
                prdata_o[6:4] = res_count_i;
            end
            default:         prdata_o = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            op1_q   <= '0;
            op2_q   <= '0;
            flags_q <= '0;
        end else begin
            if (access && pwrite_i && (paddr_i == `ALU_REG_OP1)) begin
                op1_q <= pwdata_i;
            end
            if (access && pwrite_i && (paddr_i == `ALU_REG_OP2)) begin
                op2_q <= pwdata_i;
            end
            // flags follow the entry popped by the result read
            if (res.valid && res.ready) begin
                flags_q <= res.payload.flags;
            end
        end
    end

endmodule

/* hw/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 4
) (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  logic                       in_valid_i,
    output logic                       in_ready_o,
    input  logic [WIDTH-1:0]           in_data_i,
    output logic                       out_valid_o,
    input  logic                       out_ready_i,
    output logic [WIDTH-1:0]           out_data_o,
    output logic [$clog2(DEPTH+1)-1:0] count_o
);

    localparam int PTR_W = $clog2(DEPTH);

    logic [WIDTH-1:0]           mem [DEPTH];
    logic [PTR_W-1:0]           wr_ptr_q;
    logic [PTR_W-1:0]           rd_ptr_q;
    logic [$clog2(DEPTH+1)-1:0] count_q;
    logic                       push;
    logic                       pop;

    assign in_ready_o  = count_q != DEPTH;
    assign out_valid_o = count_q != 0;
    assign out_data_o  = mem[rd_ptr_q];
    assign count_o     = count_q;
    assign push        = in_valid_i && in_ready_o;
    assign pop         = out_valid_o && out_ready_i;

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr_q] <= in_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // a full fifo has written round to the oldest entry and never counts past its depth
    a_no_overflow: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (count_q >= DEPTH) |-> (count_q == DEPTH) && (wr_ptr_q == rd_ptr_q));

    // an empty fifo has read back everything that was written
    a_no_underflow: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (count_q == 0) |-> (wr_ptr_q == rd_ptr_q));

endmodule

/* hw/seq_divider.sv */
`timescale 1ns/1ps
`include "alu_consts.svh"

module seq_divider (
    input  logic           clk_i,
    input  logic           rstn_i,
    input  logic           start_i,
    input  logic           signed_i,
    input  logic           want_rem_i,
    input  alu_pkg::data_t dividend_i,
    input  alu_pkg::data_t divisor_i,
    output logic           done_o,
    output alu_pkg::data_t result_o
);

    alu_pkg::data_t     quo_q;
    alu_pkg::data_t     rem_q;
    alu_pkg::data_t     dsr_q;
    alu_pkg::step_cnt_t step_q;
    logic               busy_q;
    logic               done_q;
    logic               neg_quo_q;
    logic               neg_rem_q;
    logic               want_rem_q;
    logic               dvd_neg;
    logic               dsr_neg;
    logic [`ALU_DATA_W:0] shifted;
    logic [`ALU_DATA_W:0] trial;

    assign dvd_neg = signed_i && dividend_i[`ALU_DATA_W-1];
    assign dsr_neg = signed_i && divisor_i[`ALU_DATA_W-1];

    // one restoring step, shift in the next dividend bit and try to subtract
    assign shifted = {rem_q, quo_q[`ALU_DATA_W-1]};
    assign trial   = shifted - {1'b0, dsr_q};

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            step_q <= '0;
        end else begin
            done_q <= busy_q && (step_q == alu_pkg::step_cnt_t'(`ALU_DATA_W - 1));
            if (start_i) begin
                busy_q <= 1'b1;
                step_q <= '0;
            end else if (busy_q) begin
                step_q <= step_q + 1'b1;
                if (step_q == alu_pkg::step_cnt_t'(`ALU_DATA_W - 1)) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            quo_q      <= dvd_neg ? -dividend_i : dividend_i;
            dsr_q      <= dsr_neg ? -divisor_i : divisor_i;
            rem_q      <= '0;
            neg_quo_q  <= dvd_neg ^ dsr_neg;
            neg_rem_q  <= dvd_neg;
            want_rem_q <= want_rem_i;
        end else if (busy_q) begin
            quo_q <= {quo_q[`ALU_DATA_W-2:0], !trial[`ALU_DATA_W]};
            rem_q <= trial[`ALU_DATA_W] ? shifted[`ALU_DATA_W-1:0] : trial[`ALU_DATA_W-1:0];
        end
    end

    // min / -1 comes out as the dividend with remainder 0 without a special case
    assign result_o = want_rem_q ? (neg_rem_q ? -rem_q : rem_q)
                                 : (neg_quo_q ? -quo_q : quo_q);
    assign done_o   = done_q;

endmodule

/* hw/alu_core.sv */
`timescale 1ns/1ps
`include "alu_consts.svh"

module alu_core (
    input  logic clk_i,
    input  logic rstn_i,
    cmd_if.snk   cmd,
    res_if.src   res
);

    localparam int GROUPS = `ALU_DATA_W / `ALU_CNT_STEP;

    alu_pkg::core_state_e state_q;
    alu_pkg::step_cnt_t   cnt_q;
    alu_pkg::uop_e        uop_q;
    alu_pkg::data_t       op1_q;
    alu_pkg::data_t       op2_q;
    alu_pkg::data_t       acc_q;
    alu_pkg::data_t       op_res;
    alu_pkg::flags_t      flags;
    alu_pkg::data_t       div_res;

    logic signed [2*`ALU_DATA_W-1:0] prod;
    logic [`ALU_CNT_STEP-1:0]        grp;
    logic [$clog2(`ALU_CNT_STEP):0]  grp_add;
    logic                            grp_hit;
    logic                            cnt_done;
    logic                            accept;
    logic                            count_op;
    logic                            div_start;
    logic                            div_signed;
    logic                            div_rem;
    logic                            div_done;

    assign cmd.ready = state_q == alu_pkg::IDLE;
    assign accept    = cmd.valid && cmd.ready;
    assign count_op  = cmd.payload.uop inside {alu_pkg::UOP_CPOP, alu_pkg::UOP_CTZ};

    // divide by zero is answered directly, the divider never sees it
    assign div_start  = accept && (cmd.payload.op2 != '0) &&
                        (cmd.payload.uop inside {alu_pkg::UOP_DIV, alu_pkg::UOP_DIVU,
                                                 alu_pkg::UOP_REM, alu_pkg::UOP_REMU});
    assign div_signed = cmd.payload.uop inside {alu_pkg::UOP_DIV, alu_pkg::UOP_REM};
    assign div_rem    = cmd.payload.uop inside {alu_pkg::UOP_REM, alu_pkg::UOP_REMU};

    seq_divider i_divider (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .start_i    (div_start),
        .signed_i   (div_signed),
        .want_rem_i (div_rem),
        .dividend_i (cmd.payload.op1),
        .divisor_i  (cmd.payload.op2),
        .done_o     (div_done),
        .result_o   (div_res)
    );

    assign flags = {op1_q == op2_q, $signed(op1_q) < $signed(op2_q), op1_q < op2_q};
    assign prod  = $signed(op1_q) * $signed(op2_q);

    always_comb begin
        case (uop_q)
            alu_pkg::UOP_AND:    op_res = op1_q & op2_q;
            alu_pkg::UOP_OR:     op_res = op1_q | op2_q;
            alu_pkg::UOP_XOR:    op_res = op1_q ^ op2_q;
            alu_pkg::UOP_SLL:    op_res = op1_q << op2_q[4:0];
            alu_pkg::UOP_SRL:    op_res = op1_q >> op2_q[4:0];
            alu_pkg::UOP_SRA:    op_res = $signed(op1_q) >>> op2_q[4:0];
            alu_pkg::UOP_SLT:    op_res = alu_pkg::data_t'(flags[1]);
            alu_pkg::UOP_SLTU:   op_res = alu_pkg::data_t'(flags[0]);
            alu_pkg::UOP_ADD:    op_res = op1_q + op2_q;
            alu_pkg::UOP_SUB:    op_res = op1_q - op2_q;
            alu_pkg::UOP_MUL:    op_res = prod[`ALU_DATA_W-1:0];
            alu_pkg::UOP_MULH:   op_res = prod[2*`ALU_DATA_W-1:`ALU_DATA_W];
            alu_pkg::UOP_DIV,
            alu_pkg::UOP_DIVU:   op_res = (op2_q == '0) ? '1 : acc_q;
            alu_pkg::UOP_REM,
            alu_pkg::UOP_REMU:   op_res = (op2_q == '0) ? op1_q : acc_q;
            alu_pkg::UOP_PACK:   op_res = {op2_q[`ALU_DATA_W/2-1:0], op1_q[`ALU_DATA_W/2-1:0]};
            alu_pkg::UOP_REV8:   op_res = {op1_q[7:0], op1_q[15:8], op1_q[23:16], op1_q[31:24]};
            alu_pkg::UOP_SH1ADD: op_res = (op1_q << 1) + op2_q;
            // cpop and ctz leave their count in the accumulator
            default:             op_res = acc_q;
        endcase
    end

    // bits of the current group, ctz stops counting at the first one
    always_comb begin
        grp     = op1_q[cnt_q*`ALU_CNT_STEP +: `ALU_CNT_STEP];
        grp_add = '0;
        grp_hit = 1'b0;
        for (int i = 0; i < `ALU_CNT_STEP; i++) begin
            if (uop_q == alu_pkg::UOP_CTZ) begin
                if (!grp_hit && !grp[i]) begin
                    grp_add = grp_add + 1'b1;
                end
                grp_hit = grp_hit || grp[i];
            end else begin
                grp_add = grp_add + grp[i];
            end
        end
    end

    assign cnt_done = (cnt_q == alu_pkg::step_cnt_t'(GROUPS - 1)) || grp_hit;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q <= alu_pkg::IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                alu_pkg::IDLE: begin
                    cnt_q <= '0;
                    if (div_start) begin
                        state_q <= alu_pkg::DIVIDE;
                    end else if (accept && count_op) begin
                        state_q <= alu_pkg::COUNT;
                    end else if (accept) begin
                        state_q <= alu_pkg::EMIT;
                    end
                end
                alu_pkg::DIVIDE: begin
                    if (div_done) begin
                        state_q <= alu_pkg::EMIT;
                    end
                end
                alu_pkg::COUNT: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_done) begin
                        state_q <= alu_pkg::EMIT;
                    end
                end
                // hold the result until the result fifo takes it
                alu_pkg::EMIT: begin
                    if (res.ready) begin
                        state_q <= alu_pkg::IDLE;
                    end
                end
                default: state_q <= alu_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            uop_q <= cmd.payload.uop;
            op1_q <= cmd.payload.op1;
            op2_q <= cmd.payload.op2;
            acc_q <= '0;
        end else if (state_q == alu_pkg::DIVIDE && div_done) begin
            acc_q <= div_res;
        end else if (state_q == alu_pkg::COUNT) begin
            acc_q <= acc_q + alu_pkg::data_t'(grp_add);
        end
    end

    assign res.valid   = state_q == alu_pkg::EMIT;
    assign res.payload = '{data: op_res, flags: flags};

    // the command fifo keeps its head steady while the core is busy
    a_cmd_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
        cmd.valid && !cmd.ready |=> cmd.valid && $stable(cmd.payload));

endmodule

/* hw/alu_apb_top.sv */
`timescale 1ns/1ps
`include "alu_consts.svh"

module alu_apb_top (
    input  logic           clk_i,
    input  logic           rstn_i,
    input  logic           psel_i,
    input  logic           penable_i,
    input  logic           pwrite_i,
    input  logic [7:0]     paddr_i,
    input  alu_pkg::data_t pwdata_i,
    output alu_pkg::data_t prdata_o,
    output logic           pready_o,
    output logic           pslverr_o
);

    // port to command fifo, command fifo to core
    cmd_if cmd_in ();
    cmd_if cmd_out ();
    // core to result fifo, result fifo to port
    res_if res_in ();
    res_if res_out ();

    logic [2:0] cmd_count;
    logic [2:0] res_count;

    apb_cmd_port i_apb_port (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .paddr_i     (paddr_i),
        .pwdata_i    (pwdata_i),
        .prdata_o    (prdata_o),
        .pready_o    (pready_o),
        .pslverr_o   (pslverr_o),
        .cmd         (cmd_in),
        .res         (res_out),
        .cmd_count_i (cmd_count),
        .res_count_i (res_count)
    );

    sync_fifo #(
        .WIDTH ($bits(alu_pkg::cmd_t)),
        .DEPTH (`ALU_CMD_DEPTH)
    ) i_cmd_fifo (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .in_valid_i  (cmd_in.valid),
        .in_ready_o  (cmd_in.ready),
        .in_data_i   (cmd_in.payload),
        .out_valid_o (cmd_out.valid),
        .out_ready_i (cmd_out.ready),
        .out_data_o  (cmd_out.payload),
        .count_o     (cmd_count)
    );

    alu_core i_core (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .cmd    (cmd_out),
        .res    (res_in)
    );

    sync_fifo #(
        .WIDTH ($bits(alu_pkg::res_t)),
        .DEPTH (`ALU_RES_DEPTH)
    ) i_res_fifo (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .in_valid_i  (res_in.valid),
        .in_ready_o  (res_in.ready),
        .in_data_i   (res_in.payload),
        .out_valid_o (res_out.valid),
        .out_ready_i (res_out.ready),
        .out_data_o  (res_out.payload),
        .count_o     (res_count)
    );

endmodule

/* testbench/alu_checker.sv */
`timescale 1ns/1ps
`include "alu_consts.svh"

module alu_checker (
    input  logic           clk_i,
    input  logic           rstn_i,
    input  logic           psel_i,
    input  logic           penable_i,
    input  logic           pwrite_i,
    input  logic [7:0]     paddr_i,
    input  alu_pkg::data_t pwdata_i,
    input  alu_pkg::data_t prdata_i,
    input  logic           pready_i,
    input  logic           pslverr_i,
    output int             err_count_o,
    output int             check_count_o
);

    alu_pkg::data_t  op1_q;
    alu_pkg::data_t  op2_q;
    alu_pkg::flags_t last_flags;
    alu_pkg::cmd_t   pending_q [$];
    alu_pkg::cmd_t   entry;
    alu_pkg::data_t  exp_data;
    logic            exp_err;
    logic [2:0]      cmd_n;
    logic [2:0]      res_n;

    initial begin
        err_count_o   = 0;
        check_count_o = 0;
    end

    // result of one command, straight from the instruction rules
    function automatic alu_pkg::data_t expected_result(input alu_pkg::uop_e code,
                                                       input alu_pkg::data_t a,
                                                       input alu_pkg::data_t b);
        longint         sa;
        longint         sb;
        longint         prod;
        logic           ovf;
        alu_pkg::data_t r;
        sa   = $signed(a);
        sb   = $signed(b);
        prod = sa * sb;
        ovf  = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        r    = '0;
        case (code)
            alu_pkg::UOP_AND:    r = a & b;
            alu_pkg::UOP_OR:     r = a | b;
            alu_pkg::UOP_XOR:    r = a ^ b;
            alu_pkg::UOP_SLL:    r = a << b[4:0];
            alu_pkg::UOP_SRL:    r = a >> b[4:0];
            alu_pkg::UOP_SRA:    r = 32'(sa >>> b[4:0]);
            alu_pkg::UOP_SLT:    r = (sa < sb) ? 32'd1 : 32'd0;
            alu_pkg::UOP_SLTU:   r = (a < b) ? 32'd1 : 32'd0;
            alu_pkg::UOP_ADD:    r = a + b;
            alu_pkg::UOP_SUB:    r = a - b;
            alu_pkg::UOP_MUL:    r = prod[31:0];
            alu_pkg::UOP_MULH:   r = prod[63:32];
            alu_pkg::UOP_DIV:    r = (b == '0) ? '1 : (ovf ? a : 32'(sa / sb));
            alu_pkg::UOP_DIVU:   r = (b == '0) ? '1 : a / b;
            alu_pkg::UOP_REM:    r = (b == '0) ? a : (ovf ? '0 : 32'(sa % sb));
            alu_pkg::UOP_REMU:   r = (b == '0) ? a : a % b;
            alu_pkg::UOP_CPOP: begin
                for (int i = 0; i < 32; i++) begin
                    r = r + 32'(a[i]);
                end
            end
            alu_pkg::UOP_CTZ: begin
                // lowest set bit wins, 32 when there is none
                r = 32'd32;
                for (int i = 31; i >= 0; i--) begin
                    if (a[i]) begin
                        r = 32'(i);
                    end
                end
            end
            alu_pkg::UOP_PACK:   r = {b[15:0], a[15:0]};
            alu_pkg::UOP_REV8:   r = {a[7:0], a[15:8], a[23:16], a[31:24]};
            alu_pkg::UOP_SH1ADD: r = (a << 1) + b;
            default:             r = '0;
        endcase
        return r;
    endfunction

    function automatic alu_pkg::flags_t expected_flags(input alu_pkg::data_t a,
                                                       input alu_pkg::data_t b);
        longint sa;
        longint sb;
        sa = $signed(a);
        sb = $signed(b);
        return {a == b, sa < sb, a < b};
    endfunction

    task automatic log_error(input string msg);
        err_count_o++;
        $display("error at %0t: %s", $time, msg);
    endtask

    always @(posedge clk_i) begin
        if (!rstn_i) begin
            op1_q      = '0;
            op2_q      = '0;
            last_flags = '0;
            pending_q.delete();
        end else if (psel_i && penable_i && !pready_i) begin
            // only a command push or a result pop may insert wait states
            if (!(pwrite_i && paddr_i == `ALU_REG_CMD) &&
                !(!pwrite_i && paddr_i == `ALU_REG_RESULT)) begin
                log_error($sformatf("wait state on access to address %h", paddr_i));
            end
        end else if (psel_i && penable_i && pready_i) begin
            exp_err = !(paddr_i inside {`ALU_REG_OP1, `ALU_REG_OP2, `ALU_REG_CMD,
                                        `ALU_REG_RESULT, `ALU_REG_FLAGS, `ALU_REG_STATUS})
                      || (pwrite_i && paddr_i == `ALU_REG_CMD && pwdata_i[4:0] > 5'd20);
            check_count_o++;
            if (pslverr_i !== exp_err) begin
                log_error($sformatf("pslverr %b at address %h, expected %b",
                                    pslverr_i, paddr_i, exp_err));
            end
            if (!exp_err && pwrite_i) begin
                case (paddr_i)
                    `ALU_REG_OP1: op1_q = pwdata_i;
                    `ALU_REG_OP2: op2_q = pwdata_i;
                    `ALU_REG_CMD: begin
                        entry.uop = alu_pkg::uop_e'(pwdata_i[4:0]);
                        entry.op1 = op1_q;
                        entry.op2 = op2_q;
                        pending_q.push_back(entry);
                    end
                    default: ;
                endcase
            end else if (!exp_err) begin
                case (paddr_i)
                    `ALU_REG_RESULT: begin
                        check_count_o++;
                        if (pending_q.size() == 0) begin
                            log_error("RESULT read with no command outstanding");
                        end else begin
                            entry      = pending_q.pop_front();
                            exp_data   = expected_result(entry.uop, entry.op1, entry.op2);
                            last_flags = expected_flags(entry.op1, entry.op2);
                            if (prdata_i !== exp_data) begin
                                log_error($sformatf("uop %0d op1 %h op2 %h gave %h, expected %h",
                                                    entry.uop, entry.op1, entry.op2,
                                                    prdata_i, exp_data));
                            end
                        end
                    end
                    `ALU_REG_FLAGS: begin
                        check_count_o++;
                        if (prdata_i !== {29'b0, last_flags}) begin
                            log_error($sformatf("FLAGS read %h, expected %h",
                                                prdata_i, last_flags));
                        end
                    end
                    `ALU_REG_STATUS: begin
                        // in flight entries can never outnumber issued commands
                        cmd_n = prdata_i[2:0];
                        res_n = prdata_i[6:4];
                        check_count_o++;
                        if (cmd_n > `ALU_CMD_DEPTH || res_n > `ALU_RES_DEPTH ||
                            int'(cmd_n) + int'(res_n) > pending_q.size()) begin
                            log_error($sformatf("STATUS counts %0d and %0d with %0d pending",
                                                cmd_n, res_n, pending_q.size()));
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

/* testbench/tb_alu_apb.sv */
`timescale 1ns/1ps
`include "alu_consts.svh"

module tb_alu_apb;

    logic           clk_i;
    logic           rstn_i;
    logic           psel_i;
    logic           penable_i;
    logic           pwrite_i;
    logic [7:0]     paddr_i;
    alu_pkg::data_t pwdata_i;
    alu_pkg::data_t prdata_o;
    logic           pready_o;
    logic           pslverr_o;

    int             seed = 81;
    int             issued = 0;
    int             cycles = 0;
    int             err_count;
    int             check_count;
    alu_pkg::data_t rdata;
    alu_pkg::data_t a;
    alu_pkg::data_t b;
    alu_pkg::data_t edge_vals [3];
    alu_pkg::data_t div_a [6];
    alu_pkg::data_t div_b [6];
    logic [4:0]     bp_codes [9];

    alu_apb_top i_dut (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o)
    );

    alu_checker i_checker (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .psel_i        (psel_i),
        .penable_i     (penable_i),
        .pwrite_i      (pwrite_i),
        .paddr_i       (paddr_i),
        .pwdata_i      (pwdata_i),
        .prdata_i      (prdata_o),
        .pready_i      (pready_o),
        .pslverr_i     (pslverr_o),
        .err_count_o   (err_count),
        .check_count_o (check_count)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // setup phase, access phase, then wait for pready
    task automatic apb_access(input logic write, input logic [7:0] addr,
                              input alu_pkg::data_t wdata, output alu_pkg::data_t data);
        @(posedge clk_i);
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        pwrite_i  <= write;
        paddr_i   <= addr;
        pwdata_i  <= wdata;
        @(posedge clk_i);
        penable_i <= 1'b1;
        @(posedge clk_i);
        while (!pready_o) begin
            @(posedge clk_i);
        end
        data = prdata_o;
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
    endtask

    task automatic write_reg(input logic [7:0] addr, input alu_pkg::data_t data);
        alu_pkg::data_t unused;
        apb_access(1'b1, addr, data, unused);
    endtask

    task automatic read_reg(input logic [7:0] addr, output alu_pkg::data_t data);
        apb_access(1'b0, addr, '0, data);
    endtask

    task automatic issue_cmd(input logic [4:0] code);
        issued++;
        write_reg(`ALU_REG_CMD, 32'(code));
    endtask

    task automatic load_cmd(input logic [4:0] code, input alu_pkg::data_t x,
                            input alu_pkg::data_t y);
        write_reg(`ALU_REG_OP1, x);
        write_reg(`ALU_REG_OP2, y);
        issue_cmd(code);
    endtask

    task automatic run_cmd(input logic [4:0] code, input alu_pkg::data_t x,
                           input alu_pkg::data_t y);
        alu_pkg::data_t data;
        load_cmd(code, x, y);
        read_reg(`ALU_REG_RESULT, data);
        read_reg(`ALU_REG_FLAGS, data);
    endtask

    // limit grows with every command put on the bus
    always @(posedge clk_i) begin
        cycles++;
        if (cycles > 40 * issued + 200) begin
            $display("timed out waiting for pready after %0d cycles", cycles);
            $display("checks: %0d  errors: %0d", check_count, err_count);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        rstn_i    = 1'b0;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        paddr_i   = '0;
        pwdata_i  = '0;
        edge_vals = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000};
        div_a     = '{32'd100, 32'hffff_ff9c, 32'd100, 32'h1234_5678, 32'h8000_0000, 32'd0};
        div_b     = '{32'd7, 32'd7, 32'hffff_fff9, 32'd0, 32'hffff_ffff, 32'd0};
        bp_codes  = '{5'd12, 5'd13, 5'd8, 5'd16, 5'd14, 5'd10, 5'd17, 5'd15, 5'd2};
        repeat (8) @(posedge clk_i);
        rstn_i <= 1'b1;

        // single-cycle ops on edge values and random words
        for (int code = 0; code <= 20; code++) begin
            if (code < 12 || code > 17) begin
                foreach (edge_vals[i]) begin
                    foreach (edge_vals[j]) begin
                        run_cmd(5'(code), edge_vals[i], edge_vals[j]);
                    end
                end
                for (int k = 0; k < 2; k++) begin
                    a = $random(seed);
                    b = $random(seed);
                    run_cmd(5'(code), a, b);
                end
                // shift amount above 31 gets masked
                a = $random(seed);
                run_cmd(5'(code), a, 32'h0000_0123);
            end
        end

        // divider, with divide by zero and min / -1
        for (int code = 12; code <= 15; code++) begin
            foreach (div_a[k]) begin
                run_cmd(5'(code), div_a[k], div_b[k]);
            end
            for (int k = 0; k < 2; k++) begin
                a = $random(seed);
                b = $random(seed);
                run_cmd(5'(code), a, b);
            end
        end

        // bit counts
        for (int k = 0; k < 6; k++) begin
            a = $random(seed);
            run_cmd(alu_pkg::UOP_CPOP, a, '0);
            run_cmd(alu_pkg::UOP_CTZ, a, '0);
            run_cmd(alu_pkg::UOP_CTZ, a | 32'd1, '0);
            run_cmd(alu_pkg::UOP_CTZ, a << 12, '0);
        end
        run_cmd(alu_pkg::UOP_CTZ, '0, '0);
        run_cmd(alu_pkg::UOP_CTZ, 32'h8000_0000, '0);
        run_cmd(alu_pkg::UOP_CPOP, '1, '0);

        // nine commands fill the command fifo, the core and the result fifo
        foreach (bp_codes[k]) begin
            a = $random(seed);
            b = $random(seed);
            load_cmd(bp_codes[k], a, b);
            read_reg(`ALU_REG_STATUS, rdata);
        end
        foreach (bp_codes[k]) begin
            read_reg(`ALU_REG_RESULT, rdata);
            read_reg(`ALU_REG_FLAGS, rdata);
            read_reg(`ALU_REG_STATUS, rdata);
        end

        // rejected code and unmapped addresses
        write_reg(`ALU_REG_OP1, 32'd5);
        issue_cmd(5'd21);
        write_reg(8'h18, 32'hdead_beef);
        read_reg(8'h1C, rdata);
        repeat (4) @(posedge clk_i);
        read_reg(`ALU_REG_STATUS, rdata);
        run_cmd(alu_pkg::UOP_ADD, 32'd3, 32'd4);

        repeat (5) @(posedge clk_i);
        $display("checks: %0d  errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+hw
hw/alu_pkg.sv
hw/alu_if.sv
hw/apb_cmd_port.sv
hw/sync_fifo.sv
hw/seq_divider.sv
hw/alu_core.sv
hw/alu_apb_top.sv
testbench/alu_checker.sv
testbench/tb_alu_apb.sv

/* Bender.yml */
package:
  name: alu_apb

dependencies: {}

sources:
  - include_dirs:
      - hw
    files:
      - hw/alu_pkg.sv
      - hw/alu_if.sv
      - hw/apb_cmd_port.sv
      - hw/sync_fifo.sv
      - hw/seq_divider.sv
      - hw/alu_core.sv
      - hw/alu_apb_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/alu_checker.sv
      - testbench/tb_alu_apb.sv
